/* source/puzzle_cfg.svh */
`ifndef PUZZLE_CFG_SVH
`define PUZZLE_CFG_SVH

// Game geometry
`define PZ_TILES        16
`define PZ_IMAGES       8
`define PZ_MATCH_GOAL   8

// Input conditioning and key buffer
`define PZ_DEBOUNCE_LEN 7
`define PZ_FIFO_DEPTH   4

// 640x480 at the pixel clock
`define VGA_HD 640
`define VGA_HF 16
`define VGA_HS 96
`define VGA_HB 48
`define VGA_HT 800
`define VGA_VD 480
`define VGA_VF 10
`define VGA_VS 2
`define VGA_VB 33
`define VGA_VT 525

`define TILE_W 160
`define TILE_H 120

`endif

/* source/puzzle_pkg.sv */
`include "puzzle_cfg.svh"

package puzzle_pkg;

    typedef logic [$clog2(`PZ_TILES)-1:0] tile_idx_t;
    typedef logic [`PZ_TILES-1:0] tile_mask_t;
    typedef logic [7:0] scan_code_t;

    // brk set on key release
    typedef struct packed {
        scan_code_t code;
        logic       brk;
    } key_event_t;

    typedef enum logic [1:0] {
        INIT,
        SHOW,
        GAME,
        FINISH
    } game_state_e;

    typedef logic [3:0] match_cnt_t;

    // Keys 1 2 3 4 / Q W E R / A S D F / Z X C V select tiles 0 to 15
    localparam scan_code_t TILE_KEYS [`PZ_TILES] = '{
        8'h16, 8'h1E, 8'h26, 8'h25,
        8'h15, 8'h1D, 8'h24, 8'h2D,
        8'h1C, 8'h1B, 8'h23, 8'h2B,
        8'h1A, 8'h22, 8'h21, 8'h2A
    };

    localparam scan_code_t KEY_SHIFT = 8'h12;
    localparam scan_code_t KEY_ENTER = 8'h5A;

    localparam tile_mask_t INIT_FLIP = tile_mask_t'(16'h000D);

endpackage

/* source/video_pkg.sv */
`include "puzzle_cfg.svh"

package video_pkg;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_ch_t;

    // Palette holds raw words, the pins take channels
    typedef union packed {
        logic [11:0] raw;
        rgb_ch_t     ch;
    } rgb_u;

    typedef logic [9:0] hcount_t;
    typedef logic [9:0] vcount_t;

    // One flat colour per image, tile i uses entry i mod 8
    localparam rgb_u PALETTE [`PZ_IMAGES] = '{
        rgb_u'(12'hF00), rgb_u'(12'h0F0), rgb_u'(12'h00F), rgb_u'(12'hFF0),
        rgb_u'(12'hF0F), rgb_u'(12'h0FF), rgb_u'(12'hFFF), rgb_u'(12'hF80)
    };

endpackage

/* source/button_pulse.sv */
`include "puzzle_cfg.svh"

module button_pulse (
    input  logic clk,
    input  logic rst,
    input  logic btn_i,
    output logic pulse_o
);

    logic [`PZ_DEBOUNCE_LEN-1:0] samples;
    logic                        level;
    logic                        level_d;

    // Debounced once every stage has seen the button high
    assign level = &samples;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            samples <= '0;
            level_d <= 1'b0;
            pulse_o <= 1'b0;
        end else begin
            samples <= {samples[`PZ_DEBOUNCE_LEN-2:0], btn_i};
            level_d <= level;
            pulse_o <= level & ~level_d;
        end
    end

endmodule

/* source/key_receiver.sv */
module key_receiver (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_i,
    input  puzzle_pkg::scan_code_t code_i,
    input  logic                   brk_i,
    input  logic                   full_i,
    output logic                   ack_o,
    output logic                   wr_en_o,
    output puzzle_pkg::key_event_t wr_event_o
);

    import puzzle_pkg::*;

    typedef enum logic {
        RX_IDLE,
        RX_ACKED
    } rx_state_e;

    rx_state_e state;

    // Take the event only when the buffer has room, otherwise it waits at the port
    assign wr_en_o = (state == RX_IDLE) && req_i && !full_i;
    assign wr_event_o = '{code: code_i, brk: brk_i};
    assign ack_o = (state == RX_ACKED);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= RX_IDLE;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (wr_en_o) begin
                        state <= RX_ACKED;
                    end
                end
                RX_ACKED: begin
                    if (!req_i) begin
                        state <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

/* source/key_event_fifo.sv */
`include "puzzle_cfg.svh"

module key_event_fifo (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wr_en_i,
    input  puzzle_pkg::key_event_t wr_event_i,
    input  logic                   rd_en_i,
    output puzzle_pkg::key_event_t rd_event_o,
    output logic                   not_empty_o,
    output logic                   full_o
);

    import puzzle_pkg::*;

    localparam int PTR_W = $clog2(`PZ_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`PZ_FIFO_DEPTH + 1);

    key_event_t       mem [`PZ_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign not_empty_o = (count != '0);
    assign full_o = (count == CNT_W'(`PZ_FIFO_DEPTH));
    assign push = wr_en_i && !full_o;
    assign pop = rd_en_i && not_empty_o;

    // Show-ahead read
    assign rd_event_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_event_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`PZ_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`PZ_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* source/pair_game.sv */
`include "puzzle_cfg.svh"

module pair_game (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_i,
    input  logic                   hint_i,
    input  puzzle_pkg::key_event_t event_i,
    input  logic                   event_valid_i,
    output logic                   rd_en_o,
    output puzzle_pkg::tile_mask_t shown_o,
    output puzzle_pkg::tile_mask_t flip_o,
    output logic                   pass_o
);

    import puzzle_pkg::*;

    localparam int IMG_W = $clog2(`PZ_IMAGES);

    game_state_e state;
    tile_mask_t  matched;
    match_cnt_t  match_cnt;
    logic        shift_held;
    logic        pend_valid;
    tile_idx_t   pend_tile;
    logic        key_hit;
    tile_idx_t   key_tile;
    logic        record_pending;
    logic        pair_match;

    // Every buffered event is consumed; outside GAME it is dropped
    assign rd_en_o = event_valid_i;

    always_comb begin
        key_hit  = 1'b0;
        key_tile = '0;
        for (int i = 0; i < `PZ_TILES; i++) begin
            if (event_i.code == TILE_KEYS[i]) begin
                key_hit  = 1'b1;
                key_tile = tile_idx_t'(i);
            end
        end
    end

    assign record_pending = (state == GAME) && event_valid_i && !event_i.brk && key_hit
                            && !shift_held && !pend_valid;

    // Same image, same orientation, and both still unmatched
    assign pair_match = (pend_tile[IMG_W-1:0] == key_tile[IMG_W-1:0])
                        && (flip_o[pend_tile] == flip_o[key_tile])
                        && !matched[pend_tile] && !matched[key_tile];

    always_ff @(posedge clk) begin
        if (record_pending) begin
            pend_tile <= key_tile;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= INIT;
            shown_o    <= '0;
            flip_o     <= INIT_FLIP;
            matched    <= '0;
            match_cnt  <= '0;
            shift_held <= 1'b0;
            pend_valid <= 1'b0;
            pass_o     <= 1'b0;
        end else begin
            case (state)
                INIT: begin
                    shown_o <= '0;
                    flip_o  <= INIT_FLIP;
                    pass_o  <= 1'b0;
                    if (start_i) begin
                        state <= SHOW;
                    end
                end
                SHOW: begin
                    shown_o <= '1;
                    flip_o  <= INIT_FLIP;
                    if (start_i) begin
                        state      <= GAME;
                        shown_o    <= '0;
                        matched    <= '0;
                        match_cnt  <= '0;
                        shift_held <= 1'b0;
                        pend_valid <= 1'b0;
                    end
                end
                GAME: begin
                    if (match_cnt == match_cnt_t'(`PZ_MATCH_GOAL)) begin
                        state <= FINISH;
                    end else begin
                        if (event_valid_i) begin
                            if (event_i.brk) begin
                                if (event_i.code == KEY_SHIFT) begin
                                    shift_held <= 1'b0;
                                end
                            end else if (event_i.code == KEY_SHIFT) begin
                                shift_held <= 1'b1;
                            end else if (event_i.code == KEY_ENTER) begin
                                shown_o <= shown_o & matched;
                            end else if (key_hit) begin
                                if (shift_held) begin
                                    flip_o[key_tile]  <= ~flip_o[key_tile];
                                    shown_o[key_tile] <= 1'b1;
                                end else if (!pend_valid) begin
                                    pend_valid <= 1'b1;
                                end else if (pend_tile != key_tile) begin
                                    shown_o[pend_tile] <= 1'b1;
                                    shown_o[key_tile]  <= 1'b1;
                                    pend_valid         <= 1'b0;
                                    if (pair_match) begin
                                        matched[pend_tile] <= 1'b1;
                                        matched[key_tile]  <= 1'b1;
                                        match_cnt          <= match_cnt + 1'b1;
                                    end
                                end
                            end
                        end
                        // Hint wins over a same-cycle hide
                        if (hint_i) begin
                            shown_o <= '1;
                        end
                    end
                end
                FINISH: begin
                    shown_o <= '1;
                    pass_o  <= 1'b1;
                    if (start_i) begin
                        state <= INIT;
                    end
                end
                default: state <= INIT;
            endcase
        end
    end

endmodule

/* source/vga_tile_display.sv */
`include "puzzle_cfg.svh"

module vga_tile_display (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`PZ_TILES-1:0]  shown_i,
    input  logic [`PZ_TILES-1:0]  flip_i,
    output video_pkg::rgb_u       rgb_o,
    output logic                  hsync_o,
    output logic                  vsync_o
);

    import video_pkg::*;

    localparam int TILE_W_BITS = $clog2(`PZ_TILES);
    localparam int IMG_W = $clog2(`PZ_IMAGES);

    hcount_t                h_cnt;
    vcount_t                v_cnt;
    logic [9:0]             col;
    logic [9:0]             row;
    vcount_t                y_off;
    logic [TILE_W_BITS-1:0] tile;
    logic                   active;
    logic                   upper;
    logic                   lit;
    logic                   hsync_n;
    logic                   vsync_n;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == hcount_t'(`VGA_HT - 1)) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == vcount_t'(`VGA_VT - 1)) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign active = (h_cnt < hcount_t'(`VGA_HD)) && (v_cnt < vcount_t'(`VGA_VD));

    // 4x4 grid, row-major tile numbering
    assign col = 10'(h_cnt / `TILE_W);
    assign row = 10'(v_cnt / `TILE_H);
    assign tile = {row[1:0], col[1:0]};
    assign y_off = vcount_t'(v_cnt % `TILE_H);
    assign upper = (y_off < vcount_t'(`TILE_H / 2));

    // Flipped tiles carry their colour in the lower half
    assign lit = active && shown_i[tile] && (upper ^ flip_i[tile]);

    assign hsync_n = (h_cnt >= hcount_t'(`VGA_HD + `VGA_HF))
                     && (h_cnt < hcount_t'(`VGA_HD + `VGA_HF + `VGA_HS));
    assign vsync_n = (v_cnt >= vcount_t'(`VGA_VD + `VGA_VF))
                     && (v_cnt < vcount_t'(`VGA_VD + `VGA_VF + `VGA_VS));

    // Colour and syncs leave together, one cycle after the counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rgb_o   <= '0;
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
        end else begin
            rgb_o   <= lit ? PALETTE[tile[IMG_W-1:0]] : rgb_u'(12'h000);
            hsync_o <= ~hsync_n;
            vsync_o <= ~vsync_n;
        end
    end

endmodule

/* source/puzzle_top.sv */
module puzzle_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_i,
    input  logic                   hint_i,
    input  logic                   key_req_i,
    input  puzzle_pkg::scan_code_t key_code_i,
    input  logic                   key_brk_i,
    output logic                   key_ack_o,
    output logic [3:0]             vga_red_o,
    output logic [3:0]             vga_green_o,
    output logic [3:0]             vga_blue_o,
    output logic                   hsync_o,
    output logic                   vsync_o,
    output logic                   pass_o
);

    import puzzle_pkg::*;
    import video_pkg::*;

    logic       start_pulse;
    logic       hint_pulse;
    logic       wr_en;
    key_event_t wr_event;
    logic       full;
    key_event_t rd_event;
    logic       not_empty;
    logic       rd_en;
    tile_mask_t shown;
    tile_mask_t flip;
    rgb_u       rgb;

    button_pulse start_btn_inst (
        .clk     (clk),
        .rst     (rst),
        .btn_i   (start_i),
        .pulse_o (start_pulse)
    );

    button_pulse hint_btn_inst (
        .clk     (clk),
        .rst     (rst),
        .btn_i   (hint_i),
        .pulse_o (hint_pulse)
    );

    key_receiver key_receiver_inst (
        .clk        (clk),
        .rst        (rst),
        .req_i      (key_req_i),
        .code_i     (key_code_i),
        .brk_i      (key_brk_i),
        .full_i     (full),
        .ack_o      (key_ack_o),
        .wr_en_o    (wr_en),
        .wr_event_o (wr_event)
    );

    key_event_fifo key_event_fifo_inst (
        .clk         (clk),
        .rst         (rst),
        .wr_en_i     (wr_en),
        .wr_event_i  (wr_event),
        .rd_en_i     (rd_en),
        .rd_event_o  (rd_event),
        .not_empty_o (not_empty),
        .full_o      (full)
    );

    pair_game pair_game_inst (
        .clk           (clk),
        .rst           (rst),
        .start_i       (start_pulse),
        .hint_i        (hint_pulse),
        .event_i       (rd_event),
        .event_valid_i (not_empty),
        .rd_en_o       (rd_en),
        .shown_o       (shown),
        .flip_o        (flip),
        .pass_o        (pass_o)
    );

    vga_tile_display vga_tile_display_inst (
        .clk     (clk),
        .rst     (rst),
        .shown_i (shown),
        .flip_i  (flip),
        .rgb_o   (rgb),
        .hsync_o (hsync_o),
        .vsync_o (vsync_o)
    );

    assign vga_red_o   = rgb.ch.r;
    assign vga_green_o = rgb.ch.g;
    assign vga_blue_o  = rgb.ch.b;

endmodule

/* dv/puzzle_properties.sv */
module puzzle_properties (
    input logic clk,
    input logic rst,
    input logic key_req_i,
    input logic key_ack_o,
    input logic hsync_o,
    input logic vsync_o
);

    timeunit 1ns;
    timeprecision 1ps;

    int hs_low_cnt;
    int hs_since_fall;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hs_low_cnt    <= 0;
            hs_since_fall <= 0;
        end else begin
            hs_low_cnt    <= hsync_o ? 0 : hs_low_cnt + 1;
            hs_since_fall <= (!hsync_o && hs_low_cnt == 0) ? 0 : hs_since_fall + 1;
        end
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(key_ack_o) |-> $past(key_req_i))
        else $error("ack rose without a request");

    ack_holds: assert property (@(posedge clk) disable iff (rst)
        (key_ack_o && key_req_i) |=> key_ack_o)
        else $error("ack dropped while req was still high");

    hsync_not_long: assert property (@(posedge clk) disable iff (rst)
        !hsync_o |-> (hs_low_cnt < 96))
        else $error("hsync low for more than 96 cycles");

    hsync_not_short: assert property (@(posedge clk) disable iff (rst)
        $rose(hsync_o) |-> (hs_low_cnt == 96))
        else $error("hsync low pulse shorter than 96 cycles");

    // Line timing keeps running through the vertical pulse
    vsync_with_hsync: assert property (@(posedge clk) disable iff (rst)
        !vsync_o |-> (hs_since_fall < 800))
        else $error("vsync low while hsync stalled");

endmodule

bind puzzle_top puzzle_properties puzzle_properties_inst (
    .clk       (clk),
    .rst       (rst),
    .key_req_i (key_req_i),
    .key_ack_o (key_ack_o),
    .hsync_o   (hsync_o),
    .vsync_o   (vsync_o)
);

/* dv/puzzle_tb.sv */
`include "puzzle_cfg.svh"

module puzzle_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import puzzle_pkg::*;
    import video_pkg::*;

    localparam int FRAME_CYCLES = `VGA_HT * `VGA_VT;
    // 25 frames of waiting, plus 20 percent
    localparam int TIMEOUT_CYCLES = 25 * 420000 * 12 / 10;
    localparam int ACK_WAIT = 64;

    logic       clk = 1'b0;
    logic       rst;
    logic       start_i;
    logic       hint_i;
    logic       key_req_i;
    scan_code_t key_code_i;
    logic       key_brk_i;
    logic       key_ack_o;
    logic [3:0] vga_red_o;
    logic [3:0] vga_green_o;
    logic [3:0] vga_blue_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       pass_o;
    rgb_u       dut_rgb;

    int         seed = 90373;
    int         cycles;
    int         ack_count;
    rgb_u       up_s [`PZ_TILES];
    rgb_u       lo_s [`PZ_TILES];

    // Reference game state
    tile_mask_t m_shown;
    tile_mask_t m_flip;
    tile_mask_t m_matched;
    logic       m_shift;
    logic       m_pend_v;
    int         m_pend;

    assign dut_rgb = {vga_red_o, vga_green_o, vga_blue_o};

    puzzle_top puzzle_top_inst (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start_i),
        .hint_i      (hint_i),
        .key_req_i   (key_req_i),
        .key_code_i  (key_code_i),
        .key_brk_i   (key_brk_i),
        .key_ack_o   (key_ack_o),
        .vga_red_o   (vga_red_o),
        .vga_green_o (vga_green_o),
        .vga_blue_o  (vga_blue_o),
        .hsync_o     (hsync_o),
        .vsync_o     (vsync_o),
        .pass_o      (pass_o)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                stop_with_error("Timeout: the run went past its cycle limit");
            end
        end
    end

    // Ack pulses seen on the port
    always @(posedge key_ack_o) begin
        ack_count++;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task automatic check_rgb(input string name, input rgb_u exp_v, input rgb_u act_v);
        if (act_v !== exp_v) begin
            stop_with_error($sformatf("Error at %0t: %s expected %h, got %h",
                                      $time, name, exp_v.raw, act_v.raw));
        end
    endtask

    task automatic check_bit(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            stop_with_error($sformatf("Error at %0t: %s expected %b, got %b",
                                      $time, name, exp_v, act_v));
        end
    endtask

    task automatic check_count(input string name, input int exp_v, input int act_v);
        if (act_v != exp_v) begin
            stop_with_error($sformatf("Error at %0t: %s expected %0d, got %0d",
                                      $time, name, exp_v, act_v));
        end
    endtask

    task automatic press_button(input bit is_hint);
        @(negedge clk);
        if (is_hint) hint_i = 1'b1;
        else start_i = 1'b1;
        repeat (16) @(negedge clk);
        hint_i  = 1'b0;
        start_i = 1'b0;
        repeat (12) @(negedge clk);
    endtask

    task automatic send_key(input scan_code_t code, input logic brk);
        int n;
        @(negedge clk);
        key_code_i = code;
        key_brk_i  = brk;
        key_req_i  = 1'b1;
        n = 0;
        while (!key_ack_o) begin
            @(negedge clk);
            n++;
            if (n > ACK_WAIT) stop_with_error("Key handshake failed: ack never came");
        end
        key_req_i = 1'b0;
        n = 0;
        while (key_ack_o) begin
            @(negedge clk);
            n++;
            if (n > ACK_WAIT) stop_with_error("Key handshake failed: ack never dropped");
        end
    endtask

    // Bounded wait for a sync level, sampled on the falling edge
    task automatic wait_sync(input bit is_v, input logic level);
        int n;
        n = 0;
        while ((is_v ? vsync_o : hsync_o) !== level) begin
            @(negedge clk);
            n++;
            if (n > 2 * FRAME_CYCLES) stop_with_error("A sync output stopped toggling");
        end
    endtask

    task automatic sample_frame();
        int t;
        int target;
        wait_sync(1'b1, 1'b0);
        wait_sync(1'b1, 1'b1);
        // Now at line 492, pixel 0
        t = 0;
        for (int r = 0; r < 4; r++) begin
            for (int half = 0; half < 2; half++) begin
                for (int c = 0; c < 4; c++) begin
                    target = (`VGA_VT - 492) * `VGA_HT
                             + (120 * r + 30 + 60 * half) * `VGA_HT + 160 * c + 80;
                    while (t < target) begin
                        @(negedge clk);
                        t++;
                    end
                    if (half == 0) up_s[4 * r + c] = dut_rgb;
                    else lo_s[4 * r + c] = dut_rgb;
                end
            end
        end
    endtask

    task automatic check_screen(input string tag);
        rgb_u exp_up;
        rgb_u exp_lo;
        sample_frame();
        for (int i = 0; i < `PZ_TILES; i++) begin
            exp_up = (m_shown[i] && !m_flip[i]) ? PALETTE[i % 8] : rgb_u'(12'h000);
            exp_lo = (m_shown[i] && m_flip[i]) ? PALETTE[i % 8] : rgb_u'(12'h000);
            check_rgb($sformatf("%s tile %0d upper rgb", tag, i), exp_up, up_s[i]);
            check_rgb($sformatf("%s tile %0d lower rgb", tag, i), exp_lo, lo_s[i]);
        end
    endtask

    task automatic model_tile(input int t);
        if (m_shift) begin
            m_flip[t]  = ~m_flip[t];
            m_shown[t] = 1'b1;
        end else if (!m_pend_v) begin
            m_pend   = t;
            m_pend_v = 1'b1;
        end else if (m_pend != t) begin
            m_shown[m_pend] = 1'b1;
            m_shown[t]      = 1'b1;
            m_pend_v        = 1'b0;
            if ((m_pend % 8 == t % 8) && (m_flip[m_pend] == m_flip[t])
                && !m_matched[m_pend] && !m_matched[t]) begin
                m_matched[m_pend] = 1'b1;
                m_matched[t]      = 1'b1;
            end
        end
    endtask

    task automatic tap_tile(input int t);
        send_key(TILE_KEYS[t], 1'b0);
        send_key(TILE_KEYS[t], 1'b1);
        model_tile(t);
    endtask

    task automatic tap_enter();
        send_key(KEY_ENTER, 1'b0);
        send_key(KEY_ENTER, 1'b1);
        m_shown = m_shown & m_matched;
    endtask

    task automatic flip_tile(input int t);
        send_key(KEY_SHIFT, 1'b0);
        m_shift = 1'b1;
        tap_tile(t);
        send_key(KEY_SHIFT, 1'b1);
        m_shift = 1'b0;
    endtask

    function automatic bit is_known(input scan_code_t code);
        bit hit;
        hit = (code == KEY_SHIFT) || (code == KEY_ENTER);
        for (int i = 0; i < `PZ_TILES; i++) begin
            if (code == TILE_KEYS[i]) hit = 1'b1;
        end
        return hit;
    endfunction

    task automatic test_reset_and_sync();
        int n;
        check_bit("hsync_o", 1'b1, hsync_o);
        check_bit("vsync_o", 1'b1, vsync_o);
        check_bit("pass_o", 1'b0, pass_o);
        wait_sync(1'b0, 1'b0);
        n = 0;
        while (!hsync_o) begin
            @(negedge clk);
            n++;
        end
        check_count("hsync_o low cycles", 96, n);
        while (hsync_o) begin
            @(negedge clk);
            n++;
        end
        check_count("hsync_o period", 800, n);
        wait_sync(1'b1, 1'b0);
        n = 0;
        while (!vsync_o) begin
            @(negedge clk);
            n++;
        end
        check_count("vsync_o low cycles", 1600, n);
        check_screen("init");
    endtask

    task automatic test_show_and_game();
        press_button(1'b0);
        m_shown = '1;
        check_screen("show");
        press_button(1'b0);
        m_shown = '0;
        check_screen("game start");
        tap_tile(0);
        tap_tile(1);
        check_screen("keys 1 2");
        tap_enter();
        check_screen("enter");
        press_button(1'b1);
        m_shown = '1;
        check_screen("hint");
        tap_enter();
    endtask

    task automatic test_flip_and_match();
        flip_tile(0);
        tap_tile(0);
        tap_tile(8);
        tap_enter();
        check_screen("match 0 8");
        // Same pair again must not add to the count
        tap_tile(0);
        tap_tile(8);
    endtask

    task automatic test_burst();
        scan_code_t code;
        int acks_before;
        acks_before = ack_count;
        for (int k = 0; k < 8; k++) begin
            if ($random(seed) & 1) begin
                code = scan_code_t'($random(seed));
                while (is_known(code)) code = scan_code_t'($random(seed));
                send_key(code, 1'b0);
            end else begin
                send_key(TILE_KEYS[$unsigned($random(seed)) % `PZ_TILES], 1'b1);
            end
        end
        check_count("burst acks", 8, ack_count - acks_before);
        check_screen("burst");
    endtask

    task automatic test_completion();
        int order [7];
        int j;
        int tmp;
        int a;
        for (int i = 0; i < 7; i++) order[i] = i + 1;
        for (int i = 6; i > 0; i--) begin
            j = $unsigned($random(seed)) % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 7; i++) begin
            a = order[i];
            if (i == 6) begin
                repeat (4) @(negedge clk);
                check_bit("pass_o before last pair", 1'b0, pass_o);
            end
            if (m_flip[a] != m_flip[a + 8]) flip_tile(a);
            tap_tile(a);
            tap_tile(a + 8);
        end
        j = 0;
        while (!pass_o) begin
            @(negedge clk);
            j++;
            if (j > 16) stop_with_error("pass_o never rose after the last pair");
        end
        m_shown = '1;
        check_screen("finish");
        press_button(1'b0);
        check_bit("pass_o after restart", 1'b0, pass_o);
        m_shown = '0;
        check_screen("back to init");
    endtask

    initial begin
        rst        = 1'b1;
        start_i    = 1'b0;
        hint_i     = 1'b0;
        key_req_i  = 1'b0;
        key_code_i = '0;
        key_brk_i  = 1'b0;
        ack_count  = 0;
        m_shown    = '0;
        m_flip     = INIT_FLIP;
        m_matched  = '0;
        m_shift    = 1'b0;
        m_pend_v   = 1'b0;
        m_pend     = 0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        test_reset_and_sync();
        test_show_and_game();
        test_flip_and_match();
        test_burst();
        test_completion();

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* sim.f */
+incdir+source
source/puzzle_pkg.sv
source/video_pkg.sv
source/button_pulse.sv
source/key_receiver.sv
source/key_event_fifo.sv
source/pair_game.sv
source/vga_tile_display.sv
source/puzzle_top.sv
dv/puzzle_properties.sv
dv/puzzle_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the puzzle testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 -f sim.f --top-module puzzle_tb -o Vpuzzle_tb
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/Vpuzzle_tb 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
fi

if echo "$sim_output" | grep -q "Finished with no errors"; then
    exit 0
fi
exit 1
